/* all.f */
+incdir+logic
logic/ccdCamPkg.sv
logic/resetDelay.sv
logic/ccdCapture.sv
logic/bayerToRgb.sv
logic/frameArbiter.sv
logic/frameStore.sv
logic/hostPort.sv
logic/ccdCamTop.sv
test/ccdCam_sva.sv
test/ccdCamTb.sv

/* logic/bayerToRgb.sv */
`timescale 1ns/1ps
`include "ccdCam_defs.svh"
`default_nettype none

module bayerToRgb
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,
	input wire rawBeat_s rawIn,	// From capture, no stall
	output memReq_s wrReq	// Pixel write to the arbiter
);

	rawSample_t lineBuf [`FRAME_W];	// Even row: green, red, green, red
	rawSample_t prevSample;	// Blue left of the current green
	rawSample_t redS;
	rawSample_t greenA;	// Green of the even row
	logic [`RAW_W:0] greenSum;	// One spare bit for the carry
	logic cellDone;	// Bottom right of a 2x2 cell

	// Odd row, odd column closes a cell
	assign cellDone = rawIn.valid & rawIn.row[0] & rawIn.col[0];
	assign redS = lineBuf[rawIn.col];
	assign greenA = lineBuf[colIdx_t'(rawIn.col - 1'b1)];
	assign greenSum = {1'b0, greenA} + {1'b0, rawIn.sample};

	//====================================================================
	// Line buffer
	//====================================================================
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (rawIn.valid && !rawIn.row[0])
			lineBuf[rawIn.col] <= rawIn.sample;	// Keep the upper row of the cell
		if (rawIn.valid)
			prevSample <= rawIn.sample;
	end

	//====================================================================
	// Binned pixel write
	//====================================================================
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (!rstN)
		begin
			wrReq.en <= 1'b0;
			wrReq.we <= 1'b0;
		end
		else
		begin
			wrReq.en <= cellDone;	// At most every other cycle
			wrReq.we <= cellDone;
		end
		// Cell row times cells per line plus cell column
		wrReq.addr <= pixAddr_t'((rawIn.row >> 1) * (`FRAME_W / 2) + (rawIn.col >> 1));
		wrReq.wdata <= {
			redS[`RAW_W-1 -: `CH_W],	// Red, upper bits
			greenSum[`RAW_W -: `CH_W],	// Mean of both greens
			prevSample[`RAW_W-1 -: `CH_W]	// Blue
		};
	end

endmodule

`default_nettype wire

/* logic/ccdCamPkg.sv */
`include "ccdCam_defs.svh"

`default_nettype none

package ccdCamPkg;

	typedef logic [`RAW_W-1:0] rawSample_t;	// One sensor sample
	typedef logic [$clog2(`FRAME_W)-1:0] colIdx_t;	// Raw column
	typedef logic [$clog2(`FRAME_H)-1:0] rowIdx_t;	// Raw row
	typedef logic [$clog2(`PIX_COUNT)-1:0] pixAddr_t;	// RGB pixel index
	typedef logic [3*`CH_W-1:0] rgbWord_t;	// Red, green, blue from the top
	typedef logic [15:0] frameCnt_t;
	typedef logic [11:0] axiAddr_t;	// Byte address
	typedef logic [31:0] axiData_t;

	// Last owner of the frame store port
	typedef enum logic {GrantWriter, GrantHost} grant_e;

	typedef struct packed {
		rawSample_t data;
		logic lval;	// Line valid
		logic fval;	// Frame valid
	} ccdBus_s;

	typedef struct packed {
		rawSample_t sample;
		colIdx_t col;
		rowIdx_t row;
		logic valid;	// Only inside an accepted frame
	} rawBeat_s;

	typedef struct packed {
		logic en;
		logic we;
		pixAddr_t addr;
		rgbWord_t wdata;
	} memReq_s;

	typedef struct packed {
		logic awvalid;
		axiAddr_t awaddr;
		logic wvalid;
		axiData_t wdata;
		logic bready;
		logic arvalid;
		axiAddr_t araddr;
		logic rready;
	} axiReq_s;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		axiData_t rdata;
		logic [1:0] rresp;
	} axiRsp_s;

endpackage

`default_nettype wire

/* logic/ccdCamTop.sv */
`timescale 1ns/1ps
`default_nettype none

module ccdCamTop
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,
	input wire ccdBus_s ccdIn,	// Raw sensor bus
	input wire axiReq_s axiIn,	// Host bus
	output axiRsp_s axiOut,
	output logic sensorRstN	// To the sensor
);

	logic ready;
	logic captureEnable;
	rawBeat_s rawBeat;
	frameCnt_t frameCount;
	memReq_s wrReq;	// Writer side
	memReq_s hostReq;	// Host side
	memReq_s memReq;	// Granted access
	logic hostGrant;
	rgbWord_t memRdata;

	resetDelay u0 (
		.CCD_PIXCLK(CCD_PIXCLK),
		.rstN(rstN),
		.sensorRstN(sensorRstN),
		.ready(ready)
	);

	ccdCapture u1 (
		.CCD_PIXCLK(CCD_PIXCLK),
		.rstN(rstN),
		.ccdIn(ccdIn),
		.ready(ready),
		.captureEnable(captureEnable),
		.rawOut(rawBeat),
		.frameCount(frameCount)
	);

	bayerToRgb u2 (
		.CCD_PIXCLK(CCD_PIXCLK),
		.rstN(rstN),
		.rawIn(rawBeat),
		.wrReq(wrReq)
	);

	frameArbiter u3 (
		.CCD_PIXCLK(CCD_PIXCLK),
		.rstN(rstN),
		.wrReq(wrReq),
		.hostReq(hostReq),
		.hostGrant(hostGrant),
		.memReq(memReq)
	);

	frameStore u4 (
		.CCD_PIXCLK(CCD_PIXCLK),
		.memReq(memReq),
		.rdata(memRdata)
	);

	hostPort u5 (
		.CCD_PIXCLK(CCD_PIXCLK),
		.rstN(rstN),
		.axiIn(axiIn),
		.axiOut(axiOut),
		.frameCount(frameCount),
		.memReq(hostReq),
		.hostGrant(hostGrant),
		.memRdata(memRdata),
		.captureEnable(captureEnable)
	);

endmodule

`default_nettype wire

/* logic/ccdCam_defs.svh */
`ifndef CCDCAM_DEFS_SVH
`define CCDCAM_DEFS_SVH

`default_nettype none

//====================================================================
// Sensor frame geometry
//====================================================================
`define FRAME_W 16	// Raw columns per line
`define FRAME_H 8	// Raw lines per frame
`define RAW_W 12	// Sensor sample width
`define CH_W 10	// Stored channel, upper raw bits
`define PIX_COUNT 32	// RGB pixels after 2x2 binning

//====================================================================
// Reset sequencing and host register map
//====================================================================
`define SENSOR_RST_CYCLES 16	// Sensor out of reset
`define READY_CYCLES 64	// Pipeline trusts sensor data
`define REG_STATUS 12'h100	// Frame counter, read only
`define REG_CTRL 12'h104	// Bit 0 is capture enable

`default_nettype wire

`endif

/* logic/ccdCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module ccdCapture
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,
	input wire ccdBus_s ccdIn,	// Raw sensor bus
	input wire logic ready,	// From reset sequencer
	input wire logic captureEnable,	// Host control bit
	output rawBeat_s rawOut,	// One beat per cycle
	output frameCnt_t frameCount	// Stored frames
);

	ccdBus_s ccdReg;	// Sensor bus, registered once
	logic fvalD;
	logic lvalD;
	logic frameGate;	// Current frame is stored
	colIdx_t colCnt;
	rowIdx_t rowCnt;
	logic fvalRise;
	logic fvalFall;
	logic lvalFall;
	logic beatGate;
	colIdx_t beatCol;
	rowIdx_t beatRow;

	//====================================================================
	// Input register and edge detect
	//====================================================================
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (!rstN)
		begin
			ccdReg <= '0;
			fvalD <= 1'b0;
			lvalD <= 1'b0;
		end
		else
		begin
			ccdReg <= ccdIn;
			fvalD <= ccdReg.fval;
			lvalD <= ccdReg.lval;
		end
	end

	assign fvalRise = ccdReg.fval & ~fvalD;
	assign fvalFall = ~ccdReg.fval & fvalD;
	assign lvalFall = ~ccdReg.lval & lvalD;
	assign beatCol = fvalRise ? '0 : colCnt;	// New frame starts at origin
	assign beatRow = fvalRise ? '0 : rowCnt;
	assign beatGate = fvalRise ? (ready & captureEnable) : frameGate;	// Decided at frame start

	//====================================================================
	// Position counters and frame gate
	//====================================================================
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (!rstN)
		begin
			colCnt <= '0;
			rowCnt <= '0;
			frameGate <= 1'b0;
			frameCount <= '0;
		end
		else
		begin
			colCnt <= ccdReg.lval ? colIdx_t'(beatCol + 1'b1) : '0;	// Cleared between lines
			rowCnt <= lvalFall ? rowIdx_t'(beatRow + 1'b1) : beatRow;	// Next line at lval fall
			if (fvalRise)
				frameGate <= beatGate;
			if (fvalFall && frameGate)
				frameCount <= frameCount + 1'b1;	// Accepted frame complete
		end
	end

	always_comb
	begin
		rawOut.sample = ccdReg.data;
		rawOut.col = beatCol;
		rawOut.row = beatRow;
		rawOut.valid = ccdReg.fval & ccdReg.lval & beatGate;
	end

endmodule

`default_nettype wire

/* logic/frameArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module frameArbiter
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,
	input wire memReq_s wrReq,	// Pixel writer, always served
	input wire memReq_s hostReq,	// Host read, held until granted
	output logic hostGrant,
	output memReq_s memReq	// To frame store
);

	grant_e lastOwner;	// Port owner in the previous cycle

	// Writer first, host never twice in a row
	assign hostGrant = hostReq.en & ~wrReq.en & (lastOwner != GrantHost);

	always_comb
	begin
		if (wrReq.en)
			memReq = wrReq;
		else if (hostGrant)
			memReq = hostReq;
		else
			memReq = '0;	// Port idle
	end

	always_ff @(posedge CCD_PIXCLK)
	begin
		if (!rstN)
			lastOwner <= GrantWriter;
		else
			lastOwner <= hostGrant ? GrantHost : GrantWriter;	// Idle counts as writer
	end

endmodule

`default_nettype wire

/* logic/frameStore.sv */
`timescale 1ns/1ps
`include "ccdCam_defs.svh"
`default_nettype none

module frameStore
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire memReq_s memReq,	// Single shared port
	output rgbWord_t rdata	// Valid one cycle after the access
);

	rgbWord_t mem [`PIX_COUNT];	// One RGB word per binned pixel

	always_ff @(posedge CCD_PIXCLK)
	begin
		if (memReq.en)
		begin
			if (memReq.we)
				mem[memReq.addr] <= memReq.wdata;
			rdata <= mem[memReq.addr];	// Old contents on a write
		end
	end

endmodule

`default_nettype wire

/* logic/hostPort.sv */
`timescale 1ns/1ps
`include "ccdCam_defs.svh"
`default_nettype none

module hostPort
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,
	input wire axiReq_s axiIn,	// AXI4-Lite master side
	output axiRsp_s axiOut,
	input wire frameCnt_t frameCount,
	output memReq_s memReq,	// Read request to the arbiter
	input wire logic hostGrant,
	input wire rgbWord_t memRdata,
	output logic captureEnable	// REG_CTRL bit 0
);

	typedef enum logic [2:0] {Idle, MemWait, MemData, ReadResp, WriteResp} hostState_e;

	hostState_e state;
	axiRsp_s rsp;
	axiAddr_t addrReg;	// Address of the transaction in flight
	logic ctrlBit;	// Write data bit 0
	logic addrPix;
	logic addrMapped;

	function automatic logic isPixel(axiAddr_t a);
		return a < axiAddr_t'(`PIX_COUNT * 4);
	endfunction

	assign axiOut = rsp;
	assign addrPix = isPixel(addrReg);
	assign addrMapped = addrPix | (addrReg == `REG_STATUS) | (addrReg == `REG_CTRL);

	always_ff @(posedge CCD_PIXCLK)
	begin
		if (state == Idle)
		begin
			addrReg <= axiIn.arvalid ? axiIn.araddr : axiIn.awaddr;	// Read wins
			ctrlBit <= axiIn.wdata[0];
		end
	end

	//====================================================================
	// Transaction FSM, one in flight
	//====================================================================
	always_ff @(posedge CCD_PIXCLK)
	begin
		if (!rstN)
		begin
			state <= Idle;
			rsp <= '0;
			memReq <= '0;
			captureEnable <= 1'b1;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (axiIn.arvalid)
					begin
						rsp.arready <= 1'b1;	// One cycle pulse
						memReq.en <= isPixel(axiIn.araddr);	// Only pixels touch memory
						memReq.addr <= axiIn.araddr[2 +: $bits(pixAddr_t)];	// Word index
						state <= MemWait;
					end
					else if (axiIn.awvalid && axiIn.wvalid)
					begin
						rsp.awready <= 1'b1;	// Address and data together
						rsp.wready <= 1'b1;
						state <= WriteResp;
					end
				end
				MemWait:
				begin
					rsp.arready <= 1'b0;
					if (!memReq.en || hostGrant)
					begin
						memReq.en <= 1'b0;	// Drop request once granted
						state <= MemData;
					end
				end
				MemData:
				begin
					rsp.rvalid <= 1'b1;
					rsp.rresp <= addrMapped ? 2'b00 : 2'b10;	// OKAY or SLVERR
					if (addrPix)
						rsp.rdata <= axiData_t'(memRdata);	// Zero extended pixel
					else if (addrReg == `REG_STATUS)
						rsp.rdata <= axiData_t'(frameCount);
					else if (addrReg == `REG_CTRL)
						rsp.rdata <= axiData_t'(captureEnable);
					else
						rsp.rdata <= '0;
					state <= ReadResp;
				end
				ReadResp:
				begin
					if (axiIn.rready)
					begin
						rsp.rvalid <= 1'b0;	// Held stable until here
						state <= Idle;
					end
				end
				WriteResp:
				begin
					if (rsp.awready)
					begin
						rsp.awready <= 1'b0;
						rsp.wready <= 1'b0;
						rsp.bvalid <= 1'b1;
						rsp.bresp <= addrMapped ? 2'b00 : 2'b10;
						if (addrReg == `REG_CTRL)
							captureEnable <= ctrlBit;
					end
					else if (axiIn.bready)
					begin
						rsp.bvalid <= 1'b0;
						state <= Idle;
					end
				end
				default:
					state <= Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/resetDelay.sv */
`timescale 1ns/1ps
`include "ccdCam_defs.svh"
`default_nettype none

module resetDelay
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,	// Board reset
	output logic sensorRstN,	// Sensor reset line, released first
	output logic ready	// Frames may be accepted
);

	logic [$clog2(`READY_CYCLES+1)-1:0] dlyCnt;	// Cycles since release, saturating

	always_ff @(posedge CCD_PIXCLK)
	begin
		if (!rstN)
		begin
			dlyCnt <= '0;
			sensorRstN <= 1'b0;	// Sensor held in reset
			ready <= 1'b0;
		end
		else
		begin
			if (dlyCnt != `READY_CYCLES)
				dlyCnt <= dlyCnt + 1'b1;	// Stops at the last threshold
			// Sensor wakes first, pipeline trusts it later
			sensorRstN <= (dlyCnt >= `SENSOR_RST_CYCLES);
			ready <= (dlyCnt >= `READY_CYCLES);
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the capture path testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module ccdCamTb -o ccdCamSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/ccdCamSim 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx ">>> PASS"; then
	exit 0
fi
echo "Pass line not found"
exit 1

/* test/ccdCamTb.sv */
`timescale 1ns/1ps
`include "ccdCam_defs.svh"
`default_nettype none

module ccdCamTb
	import ccdCamPkg::*;
();

	localparam int NUM_TESTS = 5;
	localparam int CELLS_PER_LINE = `FRAME_W / 2;
	// Frame about 150 cycles, 37 reads of at most 12 cycles each, so under 600 per row
	// Five rows plus setup stay below 3500, limit leaves a wide margin
	localparam int CYCLE_LIMIT = 20000;

	typedef struct packed {
		rawSample_t rBase;	// Even row, odd column
		rawSample_t g1Base;	// Even row, even column
		rawSample_t g2Base;	// Odd row, odd column
		rawSample_t bBase;	// Odd row, even column
		logic capEn;	// REG_CTRL value for the frame
		frameCnt_t expCount;	// REG_STATUS after the frame
	} testVec_s;

	logic CCD_PIXCLK;
	logic rstN;
	ccdBus_s ccdIn;
	axiReq_s axiIn;
	axiRsp_s axiOut;
	logic sensorRstN;

	integer seed = 1419;	// Stall lengths on rready and bready
	int cycleCnt = 0;
	int linesSent;	// Progress of the frame generator
	axiData_t expMem [`PIX_COUNT];	// Model of the frame store

	string testName [NUM_TESTS] = '{
		"firstFrame",
		"secondFrame",
		"captureOff",
		"captureOn",
		"highValues"
	};

	testVec_s testTable [NUM_TESTS] = '{
		'{12'd100, 12'd200, 12'd300, 12'd400, 1'b1, 16'd1},
		'{12'd1000, 12'd1500, 12'd1700, 12'd2200, 1'b1, 16'd2},
		'{12'd3000, 12'd3100, 12'd3200, 12'd3300, 1'b0, 16'd2},	// Frame ignored
		'{12'd2500, 12'd600, 12'd900, 12'd50, 1'b1, 16'd3},
		'{12'd3599, 12'd3590, 12'd3598, 12'd1023, 1'b1, 16'd4}	// Green sum carries
	};

	ccdCamTop dut (
		.CCD_PIXCLK(CCD_PIXCLK),
		.rstN(rstN),
		.ccdIn(ccdIn),
		.axiIn(axiIn),
		.axiOut(axiOut),
		.sensorRstN(sensorRstN)
	);

	//======================================================================
	// Clock and run limit
	//======================================================================
	initial
	begin
		CCD_PIXCLK = 1'b0;
		forever #5 CCD_PIXCLK = ~CCD_PIXCLK;	// 10 ns period
	end

	always @(posedge CCD_PIXCLK)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt == CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, a handshake or frame never finished", CYCLE_LIMIT);
			$display(">>> FAIL");
			$fatal(1, "Run stopped by timeout");
		end
	end

	//======================================================================
	// Helpers
	//======================================================================
	task automatic stopOnError(string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkValue(string test, string what, axiData_t expVal, axiData_t actVal);
		assert (actVal === expVal)
		else stopOnError($sformatf("Mismatch %s %s expected %h actual %h",
			test, what, expVal, actVal));
	endtask

	task automatic nextCycle();
		@(posedge CCD_PIXCLK);
		#1;	// Inputs change away from the edge
	endtask

	// Raw sample at a sensor position, base of its channel plus 16 per RGB pixel
	function automatic rawSample_t sampleAt(testVec_s t, int r, int c);
		int pix;
		rawSample_t base;
		pix = (r / 2) * CELLS_PER_LINE + c / 2;
		if (r % 2 == 0)
			base = (c % 2 == 0) ? t.g1Base : t.rBase;
		else
			base = (c % 2 == 0) ? t.bBase : t.g2Base;
		return rawSample_t'(int'(base) + 16 * pix);
	endfunction

	// Binned word, upper channel bits, greens averaged
	function automatic axiData_t expectedPixel(testVec_s t, int p);
		int r0;
		int c0;
		int redCh;
		int greenCh;
		int blueCh;
		r0 = (p / CELLS_PER_LINE) * 2;
		c0 = (p % CELLS_PER_LINE) * 2;
		redCh = int'(sampleAt(t, r0, c0 + 1)) >> (`RAW_W - `CH_W);	// Drop low raw bits
		greenCh = ((int'(sampleAt(t, r0, c0)) + int'(sampleAt(t, r0 + 1, c0 + 1))) / 2)
			>> (`RAW_W - `CH_W);	// Mean of both greens
		blueCh = int'(sampleAt(t, r0 + 1, c0)) >> (`RAW_W - `CH_W);
		return axiData_t'((redCh << (2 * `CH_W)) | (greenCh << `CH_W) | blueCh);
	endfunction

	//======================================================================
	// Sensor frame and AXI4-Lite master
	//======================================================================
	task automatic sendFrame(testVec_s t);
		ccdIn.fval = 1'b1;	// One cycle ahead of the first line
		nextCycle();
		for (int r = 0; r < `FRAME_H; r++)
		begin
			for (int c = 0; c < `FRAME_W; c++)
			begin
				ccdIn.lval = 1'b1;
				ccdIn.data = sampleAt(t, r, c);
				nextCycle();
			end
			ccdIn.lval = 1'b0;
			ccdIn.data = '0;
			repeat (2) nextCycle();	// Line gap
			linesSent = r + 1;
		end
		ccdIn.fval = 1'b0;
		repeat (4) nextCycle();	// Count and last write settle
	endtask

	task automatic axiRead(input axiAddr_t addr, output axiData_t data, output logic [1:0] resp);
		int stall;
		int waited;
		logic accepted;
		logic gotFirst;
		axiData_t firstData;

		stall = {$random(seed)} % 4;	// rready low for 0 to 3 cycles
		axiIn.arvalid = 1'b1;
		axiIn.araddr = addr;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(negedge CCD_PIXCLK);
			accepted = axiOut.arready;
			nextCycle();
		end
		axiIn.arvalid = 1'b0;
		waited = 0;
		gotFirst = 1'b0;
		accepted = 1'b0;
		firstData = '0;
		data = '0;
		resp = '0;
		while (!accepted)
		begin
			axiIn.rready = (waited >= stall);
			@(negedge CCD_PIXCLK);
			if (axiOut.rvalid && !gotFirst)
			begin
				firstData = axiOut.rdata;	// Must survive the stall
				gotFirst = 1'b1;
			end
			if (axiOut.rvalid && axiIn.rready)
			begin
				data = axiOut.rdata;
				resp = axiOut.rresp;
				accepted = 1'b1;
			end
			nextCycle();
			waited++;
		end
		axiIn.rready = 1'b0;
		assert (data === firstData)
		else stopOnError($sformatf("Read data at address %h changed while rready was low", addr));
	endtask

	task automatic axiWrite(input axiAddr_t addr, input axiData_t data, output logic [1:0] resp);
		int stall;
		int waited;
		logic accepted;

		stall = {$random(seed)} % 4;	// bready low for 0 to 3 cycles
		axiIn.awvalid = 1'b1;
		axiIn.awaddr = addr;
		axiIn.wvalid = 1'b1;
		axiIn.wdata = data;
		accepted = 1'b0;
		while (!accepted)
		begin
			@(negedge CCD_PIXCLK);
			accepted = axiOut.awready & axiOut.wready;	// Taken together
			nextCycle();
		end
		axiIn.awvalid = 1'b0;
		axiIn.wvalid = 1'b0;
		waited = 0;
		accepted = 1'b0;
		resp = '0;
		while (!accepted)
		begin
			axiIn.bready = (waited >= stall);
			@(negedge CCD_PIXCLK);
			if (axiOut.bvalid && axiIn.bready)
			begin
				resp = axiOut.bresp;
				accepted = 1'b1;
			end
			nextCycle();
			waited++;
		end
		axiIn.bready = 1'b0;
	endtask

	// Pixels in cell rows the frame has already passed
	task automatic readDuringFrame(string name, testVec_s t);
		axiData_t data;
		axiData_t expVal;
		logic [1:0] resp;
		int p;
		for (int k = 0; k < 5; k++)
		begin
			p = 6 * k + 1;	// One pixel per cell row and more
			wait (linesSent >= 2 * (p / CELLS_PER_LINE + 1));	// Both raw rows sent
			expVal = t.capEn ? expectedPixel(t, p) : expMem[p];
			axiRead(axiAddr_t'(p * 4), data, resp);
			checkValue(name, $sformatf("pixel %0d during frame", p), expVal, data);
			checkValue(name, "rresp during frame", 32'd0, axiData_t'(resp));
		end
	endtask

	//======================================================================
	// Main sequence
	//======================================================================
	initial
	begin
		axiData_t data;
		logic [1:0] resp;
		int waited;
		int releaseCycle;
		testVec_s t;

		rstN = 1'b0;
		ccdIn = '0;
		axiIn = '0;
		linesSent = 0;
		repeat (8) @(posedge CCD_PIXCLK);	// Reset for 8 cycles
		#1;
		rstN = 1'b1;
		releaseCycle = cycleCnt;

		assert (sensorRstN === 1'b0)
		else stopOnError("sensorRstN is not low right after reset");
		waited = 0;
		while (sensorRstN !== 1'b1 && waited < 4 * `SENSOR_RST_CYCLES)
		begin
			nextCycle();
			waited++;
		end
		checkValue("reset", "sensor release cycle", axiData_t'(`SENSOR_RST_CYCLES + 1),
			axiData_t'(waited));

		axiRead(`REG_STATUS, data, resp);
		checkValue("reset", "REG_STATUS", 32'd0, data);
		axiRead(`REG_CTRL, data, resp);
		checkValue("reset", "REG_CTRL", 32'd1, data);	// Capture on by default

		while (cycleCnt < releaseCycle + `READY_CYCLES + 4)
			nextCycle();	// Pipeline ready before any frame

		axiRead(12'h200, data, resp);
		checkValue("unmapped", "rresp", 32'd2, axiData_t'(resp));	// SLVERR
		checkValue("unmapped", "rdata", 32'd0, data);
		axiWrite(12'h200, 32'd0, resp);
		checkValue("unmapped", "bresp", 32'd2, axiData_t'(resp));
		axiRead(`REG_CTRL, data, resp);
		checkValue("unmapped", "REG_CTRL after write", 32'd1, data);	// Untouched

		for (int i = 0; i < NUM_TESTS; i++)
		begin
			t = testTable[i];
			axiWrite(`REG_CTRL, axiData_t'(t.capEn), resp);
			checkValue(testName[i], "REG_CTRL bresp", 32'd0, axiData_t'(resp));
			axiRead(`REG_CTRL, data, resp);
			checkValue(testName[i], "REG_CTRL", axiData_t'(t.capEn), data);
			linesSent = 0;
			fork
				sendFrame(t);
				readDuringFrame(testName[i], t);
			join
			if (t.capEn)
			begin
				for (int p = 0; p < `PIX_COUNT; p++)
					expMem[p] = expectedPixel(t, p);	// Disabled frame keeps old words
			end
			axiRead(`REG_STATUS, data, resp);
			checkValue(testName[i], "REG_STATUS", axiData_t'(t.expCount), data);
			for (int p = 0; p < `PIX_COUNT; p++)
			begin
				axiRead(axiAddr_t'(p * 4), data, resp);
				checkValue(testName[i], $sformatf("pixel %0d", p), expMem[p], data);
				checkValue(testName[i], "rresp", 32'd0, axiData_t'(resp));
			end
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* test/ccdCam_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module ccdCam_sva
	import ccdCamPkg::*;
(
	input wire logic CCD_PIXCLK,
	input wire logic rstN,
	input wire axiReq_s axiIn,
	input wire axiRsp_s axiOut,
	input wire logic sensorRstN
);

	//======================================================================
	// Valid held until ready
	//======================================================================
	arHeld: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		axiIn.arvalid && !axiOut.arready |=> axiIn.arvalid)
		else $error("arvalid dropped before arready");

	awHeld: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		axiIn.awvalid && !axiOut.awready |=> axiIn.awvalid)
		else $error("awvalid dropped before awready");

	wHeld: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		axiIn.wvalid && !axiOut.wready |=> axiIn.wvalid)
		else $error("wvalid dropped before wready");

	rHeld: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		axiOut.rvalid && !axiIn.rready |=> axiOut.rvalid)
		else $error("rvalid dropped before rready");

	bHeld: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		axiOut.bvalid && !axiIn.bready |=> axiOut.bvalid)
		else $error("bvalid dropped before bready");

	// Read response frozen under back-pressure
	rStable: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		axiOut.rvalid && !axiIn.rready |=> $stable(axiOut.rdata) && $stable(axiOut.rresp))
		else $error("Read response changed while stalled");

	sensorMonotonic: assert property (@(posedge CCD_PIXCLK) disable iff (!rstN)
		!$fell(sensorRstN))
		else $error("sensorRstN fell after release");	// Sensor reset only once

endmodule

bind ccdCamTop ccdCam_sva protocolChecks (
	.CCD_PIXCLK(CCD_PIXCLK),
	.rstN(rstN),
	.axiIn(axiIn),
	.axiOut(axiOut),
	.sensorRstN(sensorRstN)
);

`default_nettype wire
